// ==== verilog/exec_defines.svh ====
////////////////////
// Execute back end parameters
// Data and tag widths, buffer depth, unit latencies
////////////////////
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Data path and tag widths
`define EXEC_XLEN      64
`define EXEC_TAG_W     4
// Buffer depth, equal to the sender's starting credits
`define EXEC_CREDITS   2

// Cycles from issue to write-back
`define EXEC_LAT_ALU   1
`define EXEC_LAT_MUL32 2
`define EXEC_LAT_MUL64 3
`define EXEC_LAT_DIV32 17
`define EXEC_LAT_DIV64 33
`define EXEC_SLOTS     33

`endif

// ==== verilog/exec_op_pkg.sv ====
////////////////////
// Instruction types
// Unit class, ALU opcode and the shared control word
////////////////////
package exec_op_pkg;

    typedef enum logic [1:0] {
        FU_ALU = 2'd0,
        FU_MUL = 2'd1,
        FU_DIV = 2'd2
    } fu_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SLTU = 4'd7
    } alu_op_e;

    // Multiply and divide flags
    typedef struct packed {
        logic [1:0] spare;
        logic       is_rem;   // Return remainder, divide only
        logic       is_word;  // 32-bit form
    } md_ctrl_t;

    // ALU reads an opcode, MUL and DIV read flags
    typedef union packed {
        alu_op_e  alu;
        md_ctrl_t md;
    } exec_ctrl_u;

endpackage

// ==== verilog/exec_wb_pkg.sv ====
////////////////////
// Result types
// Instruction tag and write-back source
////////////////////
`include "exec_defines.svh"

package exec_wb_pkg;

    typedef logic [`EXEC_TAG_W-1:0] wb_tag_t;

    typedef enum logic [2:0] {
        SRC_NONE = 3'd0,
        SRC_ALU  = 3'd1,
        SRC_MUL  = 3'd2,
        SRC_DIV0 = 3'd3,
        SRC_DIV1 = 3'd4
    } wb_src_e;

endpackage

// ==== verilog/score_board.sv ====
`timescale 1ns/1ns
`include "exec_defines.svh"
////////////////////
// Write-back scoreboard
// Reserves result slots and picks a free divider
////////////////////
module score_board
    import exec_op_pkg::*;
(
    input  logic clk_i,
    input  logic rstn_i,
    input  logic flush_i,
    input  logic issue_i,       // Head leaves this cycle
    input  fu_e  issue_fu_i,    // Unit class of the head
    input  logic issue_word_i,  // Head is the 32-bit form
    output logic ready_o,       // Head may issue now
    output logic div_sel_o      // Divider for the next division
);

    logic [`EXEC_SLOTS-1:0] slot_q, slot_d;  // Bit k, port busy k+1 cycles ahead
    logic [1:0][5:0]        div_cnt_q;       // Cycles left per divider
    logic [1:0]             div_free;
    logic [5:0]             lat;             // Latency of the head

    always_comb begin
        case (issue_fu_i)
            FU_MUL:  lat = issue_word_i ? 6'(`EXEC_LAT_MUL32) : 6'(`EXEC_LAT_MUL64);
            FU_DIV:  lat = issue_word_i ? 6'(`EXEC_LAT_DIV32) : 6'(`EXEC_LAT_DIV64);
            default: lat = 6'(`EXEC_LAT_ALU);
        endcase
    end

    assign div_free[0] = (div_cnt_q[0] == 6'd0);
    assign div_free[1] = (div_cnt_q[1] == 6'd0);
    assign div_sel_o   = ~div_free[0];  // Divider 0 first

    // Port free at t+lat, and a divider free for a division
    assign ready_o = ~slot_q[lat - 6'd1] & ((issue_fu_i != FU_DIV) | (|div_free));

    always_comb begin
        slot_d = slot_q >> 1;  // One cycle closer
        // ALU result lands next cycle, below the vector
        if (issue_i && lat > 6'd1) begin
            slot_d[lat - 6'd2] = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            slot_q    <= '0;
            div_cnt_q <= '0;
        end else if (flush_i) begin
            slot_q    <= '0;  // Results in flight are killed
            div_cnt_q <= '0;
        end else begin
            slot_q <= slot_d;
            for (int i = 0; i < 2; i++) begin
                if (issue_i && issue_fu_i == FU_DIV && div_sel_o == i[0]) begin
                    div_cnt_q[i] <= lat - 6'd1;  // Free again in its last cycle
                end else if (!div_free[i]) begin
                    div_cnt_q[i] <= div_cnt_q[i] - 6'd1;
                end
            end
        end
    end

endmodule

// ==== verilog/issue_fsm.sv ====
`timescale 1ns/1ns
`include "exec_defines.svh"
////////////////////
// Issue controller
// Two-entry buffer, credit return and in-order issue
////////////////////
module issue_fsm
    import exec_op_pkg::*;
    import exec_wb_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  flush_i,
    input  logic                  instr_valid_i,  // Backed by a credit
    input  fu_e                   instr_fu_i,
    input  exec_ctrl_u            instr_ctrl_i,
    input  wb_tag_t               instr_tag_i,
    input  logic [`EXEC_XLEN-1:0] instr_a_i,
    input  logic [`EXEC_XLEN-1:0] instr_b_i,
    input  logic                  sb_ready_i,     // Scoreboard clears the head
    input  logic                  div_sel_i,
    output logic                  credit_o,
    output fu_e                   head_fu_o,
    output logic                  head_word_o,
    output logic                  issue_o,
    output logic                  alu_start_o,
    output logic                  mul_start_o,
    output logic [1:0]            div_start_o,    // One-hot divider start
    output exec_ctrl_u            op_ctrl_o,
    output wb_tag_t               op_tag_o,
    output logic [`EXEC_XLEN-1:0] op_a_o,
    output logic [`EXEC_XLEN-1:0] op_b_o
);

    localparam logic [1:0] IDLE      = 2'd0;  // Buffer empty
    localparam logic [1:0] ISSUE     = 2'd1;
    localparam logic [1:0] STALL_WB  = 2'd2;  // Result slot taken
    localparam logic [1:0] STALL_DIV = 2'd3;  // Division waiting on a divider

    fu_e                   buf_fu   [`EXEC_CREDITS];
    exec_ctrl_u            buf_ctrl [`EXEC_CREDITS];
    wb_tag_t               buf_tag  [`EXEC_CREDITS];
    logic [`EXEC_XLEN-1:0] buf_a    [`EXEC_CREDITS];
    logic [`EXEC_XLEN-1:0] buf_b    [`EXEC_CREDITS];

    logic       wr_ptr_q, rd_ptr_q;  // Two entries
    logic [1:0] count_q, count_d;
    logic [1:0] state_q, state_d;
    logic       push;
    logic       credit_q;

    assign push = instr_valid_i & ~flush_i;  // Flushed requests are dropped

    // Head entry
    assign head_fu_o   = buf_fu[rd_ptr_q];
    assign op_ctrl_o   = buf_ctrl[rd_ptr_q];
    assign op_tag_o    = buf_tag[rd_ptr_q];
    assign op_a_o      = buf_a[rd_ptr_q];
    assign op_b_o      = buf_b[rd_ptr_q];
    assign head_word_o = op_ctrl_o.md.is_word;

    assign issue_o     = (state_q != IDLE) & sb_ready_i & ~flush_i;
    assign alu_start_o = issue_o & (head_fu_o == FU_ALU);
    assign mul_start_o = issue_o & (head_fu_o == FU_MUL);
    assign div_start_o = (issue_o && head_fu_o == FU_DIV) ? (div_sel_i ? 2'b10 : 2'b01) : 2'b00;
    assign credit_o    = credit_q;

    assign count_d = count_q + 2'(push) - 2'(issue_o);

    always_comb begin
        if (count_d == 2'd0) begin
            state_d = IDLE;
        end else if (issue_o || state_q == IDLE) begin
            state_d = ISSUE;  // New head, not checked yet
        end else if (head_fu_o == FU_DIV) begin
            state_d = STALL_DIV;
        end else begin
            state_d = STALL_WB;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            buf_fu[wr_ptr_q]   <= instr_fu_i;
            buf_ctrl[wr_ptr_q] <= instr_ctrl_i;
            buf_tag[wr_ptr_q]  <= instr_tag_i;
            buf_a[wr_ptr_q]    <= instr_a_i;
            buf_b[wr_ptr_q]    <= instr_b_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
            state_q  <= IDLE;
            credit_q <= 1'b0;
        end else if (flush_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
            state_q  <= IDLE;
            credit_q <= 1'b0;  // No credit for flushed entries
        end else begin
            wr_ptr_q <= wr_ptr_q ^ push;
            rd_ptr_q <= rd_ptr_q ^ issue_o;
            count_q  <= count_d;
            state_q  <= state_d;
            credit_q <= issue_o;  // Entry freed, one credit back
        end
    end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ns
`include "exec_defines.svh"
////////////////////
// Integer ALU
// One operation per cycle, registered result
////////////////////
module alu
    import exec_op_pkg::*;
    import exec_wb_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  flush_i,
    input  logic                  start_i,
    input  alu_op_e               op_i,
    input  wb_tag_t               tag_i,
    input  logic [`EXEC_XLEN-1:0] a_i,
    input  logic [`EXEC_XLEN-1:0] b_i,
    output logic                  valid_o,
    output wb_tag_t               tag_o,
    output logic [`EXEC_XLEN-1:0] result_o
);

    localparam int SHW = $clog2(`EXEC_XLEN);  // Shift amount bits

    logic [`EXEC_XLEN-1:0] res;

    always_comb begin
        res = '0;
        case (op_i)
            ALU_ADD:  res = a_i + b_i;
            ALU_SUB:  res = a_i - b_i;
            ALU_AND:  res = a_i & b_i;
            ALU_OR:   res = a_i | b_i;
            ALU_XOR:  res = a_i ^ b_i;
            ALU_SLL:  res = a_i << b_i[SHW-1:0];
            ALU_SRL:  res = a_i >> b_i[SHW-1:0];
            ALU_SLTU: res[0] = (a_i < b_i);  // Unsigned compare
            default:  res = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= start_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            tag_o    <= tag_i;
            result_o <= res;
        end
    end

endmodule

// ==== verilog/mul_unit.sv ====
`timescale 1ns/1ns
`include "exec_defines.svh"
////////////////////
// Unsigned multiplier, low product
// 32-bit form in 2 cycles, 64-bit in 3
////////////////////
module mul_unit
    import exec_wb_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  flush_i,
    input  logic                  start_i,
    input  logic                  word_i,
    input  wb_tag_t               tag_i,
    input  logic [`EXEC_XLEN-1:0] a_i,
    input  logic [`EXEC_XLEN-1:0] b_i,
    output logic                  valid_o,
    output wb_tag_t               tag_o,
    output logic [`EXEC_XLEN-1:0] result_o
);

    // Operand register, then two product stages
    logic                  v0_q, v1_q, v2_q;
    logic                  w0_q, w1_q;
    wb_tag_t               t0_q, t1_q, t2_q;
    logic [`EXEC_XLEN-1:0] a0_q, b0_q, p1_q, p2_q;
    logic [`EXEC_XLEN-1:0] prod;
    logic                  out_word;

    always_comb begin
        prod = a0_q * b0_q;  // Low half only
        if (w0_q) begin
            prod = {{(`EXEC_XLEN-32){prod[31]}}, prod[31:0]};  // Sign-extend like mulw
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            v0_q <= 1'b0;
            v1_q <= 1'b0;
            v2_q <= 1'b0;
        end else if (flush_i) begin
            v0_q <= 1'b0;
            v1_q <= 1'b0;
            v2_q <= 1'b0;
        end else begin
            v0_q <= start_i;
            v1_q <= v0_q;
            v2_q <= v1_q & ~w1_q;  // 64-bit products go one more stage
        end
    end

    always_ff @(posedge clk_i) begin
        a0_q <= a_i;
        b0_q <= b_i;
        w0_q <= word_i;
        t0_q <= tag_i;
        p1_q <= prod;
        w1_q <= w0_q;
        t1_q <= t0_q;
        p2_q <= p1_q;
        t2_q <= t1_q;
    end

    assign out_word = v1_q & w1_q;  // Never together with v2_q
    assign valid_o  = out_word | v2_q;
    assign tag_o    = out_word ? t1_q : t2_q;
    assign result_o = out_word ? p1_q : p2_q;

endmodule

// ==== verilog/div_unit.sv ====
`timescale 1ns/1ns
`include "exec_defines.svh"
////////////////////
// Iterative unsigned divider
// Radix 4, two quotient bits per step
////////////////////
module div_unit
    import exec_wb_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  flush_i,
    input  logic                  start_i,
    input  logic                  word_i,  // 32-bit operands
    input  logic                  rem_i,   // Return remainder
    input  wb_tag_t               tag_i,
    input  logic [`EXEC_XLEN-1:0] a_i,
    input  logic [`EXEC_XLEN-1:0] b_i,
    output logic                  valid_o,
    output wb_tag_t               tag_o,
    output logic [`EXEC_XLEN-1:0] result_o
);

    localparam int XL = `EXEC_XLEN;

    logic          busy_q;
    logic [5:0]    cnt_q;         // Steps left
    logic [XL-1:0] rem_q, quo_q;  // Partial remainder, dividend in and quotient out
    logic [XL-1:0] dsr_q;
    logic          word_q, sel_rem_q;
    wb_tag_t       tag_q;
    logic [XL-1:0] rem1, quo1, rem2, quo2;
    logic [XL-1:0] res;

    // One restoring step; a zero divisor gives all-ones quotient
    function automatic logic [2*XL-1:0] div_step(input logic [XL-1:0] rem,
                                                 input logic [XL-1:0] quo,
                                                 input logic [XL-1:0] dsr);
        logic [XL:0] part;
        logic [XL:0] diff;
        part = {rem, quo[XL-1]};
        diff = part - {1'b0, dsr};
        if (!diff[XL]) begin
            return {diff[XL-1:0], quo[XL-2:0], 1'b1};
        end
        return {part[XL-1:0], quo[XL-2:0], 1'b0};
    endfunction

    always_comb begin
        {rem1, quo1} = div_step(rem_q, quo_q, dsr_q);
        {rem2, quo2} = div_step(rem1, quo1, dsr_q);
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q <= 1'b0;
            cnt_q  <= 6'd0;
        end else if (flush_i) begin
            busy_q <= 1'b0;
            cnt_q  <= 6'd0;
        end else if (start_i) begin
            busy_q <= 1'b1;  // May restart in the last cycle
            cnt_q  <= word_i ? 6'(`EXEC_LAT_DIV32 - 1) : 6'(`EXEC_LAT_DIV64 - 1);
        end else if (busy_q) begin
            if (cnt_q == 6'd0) busy_q <= 1'b0;
            else               cnt_q  <= cnt_q - 6'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            rem_q     <= '0;
            quo_q     <= word_i ? {a_i[31:0], 32'd0} : a_i;  // Word operand at the top
            dsr_q     <= word_i ? {32'd0, b_i[31:0]} : b_i;
            word_q    <= word_i;
            sel_rem_q <= rem_i;
            tag_q     <= tag_i;
        end else if (busy_q && cnt_q != 6'd0) begin
            rem_q <= rem2;
            quo_q <= quo2;
        end
    end

    assign res      = sel_rem_q ? rem_q : quo_q;
    assign valid_o  = busy_q & (cnt_q == 6'd0);
    assign tag_o    = tag_q;
    assign result_o = word_q ? {{(XL-32){res[31]}}, res[31:0]} : res;

endmodule

// ==== verilog/wb_select.sv ====
`timescale 1ns/1ns
`include "exec_defines.svh"
////////////////////
// Write-back merge
// AND-OR of the one-hot unit results
////////////////////
module wb_select
    import exec_wb_pkg::*;
(
    input  logic                  alu_valid_i,
    input  wb_tag_t               alu_tag_i,
    input  logic [`EXEC_XLEN-1:0] alu_data_i,
    input  logic                  mul_valid_i,
    input  wb_tag_t               mul_tag_i,
    input  logic [`EXEC_XLEN-1:0] mul_data_i,
    input  logic                  div0_valid_i,
    input  wb_tag_t               div0_tag_i,
    input  logic [`EXEC_XLEN-1:0] div0_data_i,
    input  logic                  div1_valid_i,
    input  wb_tag_t               div1_tag_i,
    input  logic [`EXEC_XLEN-1:0] div1_data_i,
    output logic                  wb_valid_o,
    output wb_tag_t               wb_tag_o,
    output logic [`EXEC_XLEN-1:0] wb_data_o,
    output wb_src_e               wb_src_o
);

    assign wb_valid_o = alu_valid_i | mul_valid_i | div0_valid_i | div1_valid_i;

    assign wb_tag_o = ({`EXEC_TAG_W{alu_valid_i}} & alu_tag_i)
                    | ({`EXEC_TAG_W{mul_valid_i}} & mul_tag_i)
                    | ({`EXEC_TAG_W{div0_valid_i}} & div0_tag_i)
                    | ({`EXEC_TAG_W{div1_valid_i}} & div1_tag_i);

    assign wb_data_o = ({`EXEC_XLEN{alu_valid_i}} & alu_data_i)
                     | ({`EXEC_XLEN{mul_valid_i}} & mul_data_i)
                     | ({`EXEC_XLEN{div0_valid_i}} & div0_data_i)
                     | ({`EXEC_XLEN{div1_valid_i}} & div1_data_i);

    always_comb begin
        case ({alu_valid_i, mul_valid_i, div0_valid_i, div1_valid_i})
            4'b1000: wb_src_o = SRC_ALU;
            4'b0100: wb_src_o = SRC_MUL;
            4'b0010: wb_src_o = SRC_DIV0;
            4'b0001: wb_src_o = SRC_DIV1;
            default: wb_src_o = SRC_NONE;  // Idle port
        endcase
    end

endmodule

// ==== verilog/exec_top.sv ====
`timescale 1ns/1ns
`include "exec_defines.svh"
////////////////////
// Scalar execute back end
// Buffer, scoreboard, units and write-back port
////////////////////
module exec_top
    import exec_op_pkg::*;
    import exec_wb_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  instr_valid_i,
    input  fu_e                   instr_fu_i,
    input  exec_ctrl_u            instr_ctrl_i,
    input  wb_tag_t               instr_tag_i,
    input  logic [`EXEC_XLEN-1:0] instr_a_i,
    input  logic [`EXEC_XLEN-1:0] instr_b_i,
    input  logic                  flush_i,
    output logic                  credit_o,
    output logic                  wb_valid_o,
    output wb_tag_t               wb_tag_o,
    output logic [`EXEC_XLEN-1:0] wb_data_o,
    output wb_src_e               wb_src_o
);

    // Controller to scoreboard
    fu_e                   head_fu;
    logic                  head_word, issue, sb_ready, div_sel;
    // Controller to units
    logic                  alu_start, mul_start;
    logic [1:0]            div_start;
    exec_ctrl_u            op_ctrl;
    wb_tag_t               op_tag;
    logic [`EXEC_XLEN-1:0] op_a, op_b;
    // Unit results
    logic                  alu_valid, mul_valid, div0_valid, div1_valid;
    wb_tag_t               alu_tag, mul_tag, div0_tag, div1_tag;
    logic [`EXEC_XLEN-1:0] alu_res, mul_res, div0_res, div1_res;

    issue_fsm u_issue (
        .clk_i, .rstn_i, .flush_i,
        .instr_valid_i, .instr_fu_i, .instr_ctrl_i, .instr_tag_i, .instr_a_i, .instr_b_i,
        .sb_ready_i(sb_ready), .div_sel_i(div_sel), .credit_o,
        .head_fu_o(head_fu), .head_word_o(head_word), .issue_o(issue),
        .alu_start_o(alu_start), .mul_start_o(mul_start), .div_start_o(div_start),
        .op_ctrl_o(op_ctrl), .op_tag_o(op_tag), .op_a_o(op_a), .op_b_o(op_b)
    );

    score_board u_sb (
        .clk_i, .rstn_i, .flush_i,
        .issue_i(issue), .issue_fu_i(head_fu), .issue_word_i(head_word),
        .ready_o(sb_ready), .div_sel_o(div_sel)
    );

    alu u_alu (
        .clk_i, .rstn_i, .flush_i, .start_i(alu_start), .op_i(op_ctrl.alu),
        .tag_i(op_tag), .a_i(op_a), .b_i(op_b),
        .valid_o(alu_valid), .tag_o(alu_tag), .result_o(alu_res)
    );

    mul_unit u_mul (
        .clk_i, .rstn_i, .flush_i, .start_i(mul_start), .word_i(op_ctrl.md.is_word),
        .tag_i(op_tag), .a_i(op_a), .b_i(op_b),
        .valid_o(mul_valid), .tag_o(mul_tag), .result_o(mul_res)
    );

    div_unit u_div0 (
        .clk_i, .rstn_i, .flush_i, .start_i(div_start[0]),
        .word_i(op_ctrl.md.is_word), .rem_i(op_ctrl.md.is_rem),
        .tag_i(op_tag), .a_i(op_a), .b_i(op_b),
        .valid_o(div0_valid), .tag_o(div0_tag), .result_o(div0_res)
    );

    div_unit u_div1 (
        .clk_i, .rstn_i, .flush_i, .start_i(div_start[1]),
        .word_i(op_ctrl.md.is_word), .rem_i(op_ctrl.md.is_rem),
        .tag_i(op_tag), .a_i(op_a), .b_i(op_b),
        .valid_o(div1_valid), .tag_o(div1_tag), .result_o(div1_res)
    );

    wb_select u_wb (
        .alu_valid_i(alu_valid), .alu_tag_i(alu_tag), .alu_data_i(alu_res),
        .mul_valid_i(mul_valid), .mul_tag_i(mul_tag), .mul_data_i(mul_res),
        .div0_valid_i(div0_valid), .div0_tag_i(div0_tag), .div0_data_i(div0_res),
        .div1_valid_i(div1_valid), .div1_tag_i(div1_tag), .div1_data_i(div1_res),
        .wb_valid_o, .wb_tag_o, .wb_data_o, .wb_src_o
    );

endmodule

// ==== testbench/tb_exec.sv ====
`timescale 1ns/1ns
`include "exec_defines.svh"
////////////////////
// Execute back end testbench
// Trace driven requests, credit model, results matched by tag
////////////////////

module tb_clock_gen #(
    parameter int HALF_NS = 2  // 4 ns period
) (
    output logic clk_o
);
    initial clk_o = 1'b0;
    always #(HALF_NS) clk_o = ~clk_o;
endmodule

module tb_exec
    import exec_op_pkg::*;
    import exec_wb_pkg::*;
();

    localparam int          MAX_LINES = 64;
    localparam int          DRAIN     = 40;        // Idle cycles so killed results would show
    localparam int          NTAGS     = 1 << `EXEC_TAG_W;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;  // Maximal 16-bit Galois taps

    logic                  clk, rstn, instr_valid, flush;
    fu_e                   instr_fu;
    exec_ctrl_u            instr_ctrl;
    wb_tag_t               instr_tag;
    logic [`EXEC_XLEN-1:0] instr_a, instr_b;
    logic                  credit, wb_valid;
    wb_tag_t               wb_tag;
    logic [`EXEC_XLEN-1:0] wb_data;
    wb_src_e               wb_src;

    // Trace contents
    int                    tr_test [MAX_LINES];
    int                    tr_kind [MAX_LINES];  // 0 request, 1 flush
    logic [1:0]            tr_fu   [MAX_LINES];
    logic [3:0]            tr_ctrl [MAX_LINES];
    wb_tag_t               tr_tag  [MAX_LINES];
    logic [`EXEC_XLEN-1:0] tr_a    [MAX_LINES];
    logic [`EXEC_XLEN-1:0] tr_b    [MAX_LINES];
    logic [`EXEC_XLEN-1:0] tr_exp  [MAX_LINES];
    logic [2:0]            tr_src  [MAX_LINES];
    int                    n_lines;

    // Expected results, a tag is pending while exp_test differs from done_test
    int                    exp_test  [NTAGS];
    int                    done_test [NTAGS];
    logic [`EXEC_XLEN-1:0] exp_data  [NTAGS];
    wb_src_e               exp_src   [NTAGS];
    int                    cur_test;

    int          received, checks, mon_errors, main_errors, tests_run;
    int          spent, returned, returned_base;  // Credit bookkeeping
    int          cycles, cycle_limit;
    logic [15:0] lfsr;

    tb_clock_gen u_clk (.clk_o(clk));

    exec_top dut (
        .clk_i(clk), .rstn_i(rstn),
        .instr_valid_i(instr_valid), .instr_fu_i(instr_fu), .instr_ctrl_i(instr_ctrl),
        .instr_tag_i(instr_tag), .instr_a_i(instr_a), .instr_b_i(instr_b),
        .flush_i(flush), .credit_o(credit),
        .wb_valid_o(wb_valid), .wb_tag_o(wb_tag), .wb_data_o(wb_data), .wb_src_o(wb_src)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // Latency from issue to write-back, for the run limit
    function automatic int unit_latency(input logic [1:0] fu, input logic [3:0] ctrl);
        case (fu)
            2'd1:    return ctrl[0] ? `EXEC_LAT_MUL32 : `EXEC_LAT_MUL64;
            2'd2:    return ctrl[0] ? `EXEC_LAT_DIV32 : `EXEC_LAT_DIV64;
            default: return `EXEC_LAT_ALU;
        endcase
    endfunction

    function automatic int credits_held();
        return `EXEC_CREDITS - spent + (returned - returned_base);
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val  = (val << 1) | int'(lfsr[0]);  // One step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_data(input wb_tag_t tag, input logic [`EXEC_XLEN-1:0] got,
                              input logic [`EXEC_XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            mon_errors++;
            $display("Mismatch at %0t ns: tag %0d data %h, expected %h", $time, tag, got, exp);
        end
    endtask

    task automatic check_src(input wb_tag_t tag, input wb_src_e got, input wb_src_e exp);
        checks++;
        if (got !== exp) begin
            mon_errors++;
            $display("Mismatch at %0t ns: tag %0d source %s, expected %s",
                     $time, tag, got.name(), exp.name());
        end
    endtask

    // Next drive point, 1 ns after the rising edge
    task automatic next_slot();
        @(posedge clk);
        #1;
    endtask

    task automatic send_instr(input int idx);
        int gap;
        take_bits(2, gap);  // 0 to 3 idle cycles
        repeat (gap) next_slot();
        while (credits_held() == 0) next_slot();
        instr_valid = 1'b1;
        instr_fu    = fu_e'(tr_fu[idx]);
        instr_ctrl  = tr_ctrl[idx];
        instr_tag   = tr_tag[idx];
        instr_a     = tr_a[idx];
        instr_b     = tr_b[idx];
        spent++;
        next_slot();
        instr_valid = 1'b0;
    endtask

    task automatic apply_flush();
        flush         = 1'b1;
        spent         = 0;         // Sender starts over with full credit
        returned_base = returned;
        next_slot();
        flush = 1'b0;
    endtask

    task automatic run_test(input int first, input int stop, input int tnum);
        int n_exp;
        int base_rx;
        int base_err;
        n_exp    = 0;
        base_rx  = received;
        base_err = mon_errors + main_errors;
        cur_test = tnum;
        for (int k = first; k < stop; k++) begin
            if (tr_kind[k] == 0 && tr_src[k] != 3'd0) begin
                exp_data[tr_tag[k]] = tr_exp[k];
                exp_src[tr_tag[k]]  = wb_src_e'(tr_src[k]);
                exp_test[tr_tag[k]] = tnum;
                n_exp++;
            end
        end
        for (int k = first; k < stop; k++) begin
            if (tr_kind[k] == 1) apply_flush();
            else                 send_instr(k);
        end
        while (received - base_rx < n_exp) next_slot();
        repeat (2) next_slot();  // Let the last credit come home
        if (credits_held() != `EXEC_CREDITS) begin
            main_errors++;
            $display("Test %0d ended holding %0d credits instead of %0d",
                     tnum, credits_held(), `EXEC_CREDITS);
        end
        tests_run++;
        $display("Test %0d: %0d of %0d results, %s", tnum, received - base_rx, n_exp,
                 (mon_errors + main_errors == base_err) ? "ok" : "with errors");
    endtask

    task automatic read_trace(output bit ok);
        int                    fd, n, f_test, f_kind, f_fu, f_ctrl, f_tag, f_src;
        logic [`EXEC_XLEN-1:0] f_a, f_b, f_exp;
        string                 line;
        n_lines     = 0;
        cycle_limit = 3 + DRAIN + 8;  // Reset and final drain
        fd = $fopen("testbench/exec_trace.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.getc(0) == 8'h23) continue;  // Blank or comment
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_test, f_kind, f_fu,
                            f_ctrl, f_tag, f_a, f_b, f_exp, f_src);
                if (n == 9 && n_lines < MAX_LINES) begin
                    tr_test[n_lines] = f_test;
                    tr_kind[n_lines] = f_kind;
                    tr_fu[n_lines]   = f_fu[1:0];
                    tr_ctrl[n_lines] = f_ctrl[3:0];
                    tr_tag[n_lines]  = f_tag[`EXEC_TAG_W-1:0];
                    tr_a[n_lines]    = f_a;
                    tr_b[n_lines]    = f_b;
                    tr_exp[n_lines]  = f_exp;
                    tr_src[n_lines]  = f_src[2:0];
                    cycle_limit += 8 + ((f_kind == 0) ? unit_latency(f_fu[1:0], f_ctrl[3:0]) : 0);
                    n_lines++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_all();
        int i;
        int j;
        repeat (3) @(posedge clk);  // Reset for 3 cycles
        #1;
        rstn = 1'b1;
        i    = 0;
        while (i < n_lines) begin
            j = i;
            while (j < n_lines && tr_test[j] == tr_test[i]) j++;
            run_test(i, j, tr_test[i]);
            i = j;
        end
        repeat (DRAIN) next_slot();
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 tests_run, checks, mon_errors + main_errors);
        if (mon_errors + main_errors == 0 && tests_run > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    // Result and credit monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rstn) begin
            if (credit && !flush) begin
                returned++;
                if (credits_held() > `EXEC_CREDITS) begin
                    mon_errors++;
                    $display("Credit returned at %0t ns with no entry outstanding", $time);
                end
            end
            if (wb_valid) begin
                if (exp_test[wb_tag] != cur_test || done_test[wb_tag] == cur_test) begin
                    mon_errors++;
                    $display("Unexpected write-back at %0t ns for tag %0d", $time, wb_tag);
                end else begin
                    check_data(wb_tag, wb_data, exp_data[wb_tag]);
                    check_src(wb_tag, wb_src, exp_src[wb_tag]);
                    done_test[wb_tag] = cur_test;
                    received++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        bit ok;
        rstn          = 1'b0;
        instr_valid   = 1'b0;
        flush         = 1'b0;
        instr_fu      = FU_ALU;
        instr_ctrl    = '0;
        instr_tag     = '0;
        instr_a       = '0;
        instr_b       = '0;
        lfsr          = 16'd19969;
        cur_test      = 0;
        received      = 0;
        checks        = 0;
        mon_errors    = 0;
        main_errors   = 0;
        tests_run     = 0;
        spent         = 0;
        returned      = 0;
        returned_base = 0;
        cycles        = 0;
        cycle_limit   = 0;
        for (int t = 0; t < NTAGS; t++) begin
            exp_test[t]  = 0;
            done_test[t] = 0;
        end
        read_trace(ok);
        if (!ok) begin
            $display("Could not open the trace file testbench/exec_trace.txt");
            $display("STATUS: FAIL");
            $finish;
        end else begin
            run_all();
        end
    end

endmodule

// ==== scalar_exec.f ====
+incdir+verilog
verilog/exec_op_pkg.sv
verilog/exec_wb_pkg.sv
verilog/score_board.sv
verilog/issue_fsm.sv
verilog/alu.sv
verilog/mul_unit.sv
verilog/div_unit.sv
verilog/wb_select.sv
verilog/exec_top.sv
testbench/tb_exec.sv

// ==== Makefile ====
# Verilator build and run for the scalar execute back end

VERILATOR ?= verilator
TOP       ?= tb_exec
FILELIST  ?= scalar_exec.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/exec_trace.txt ====
# test kind(0 instr, 1 flush) fu ctrl tag a b expected src (all hex)
# src 0 marks an instruction that must not write back
1 0 0 0 0 0000000000000010 0000000000000003 0000000000000013 1
1 0 0 1 1 0000000000000003 0000000000000010 FFFFFFFFFFFFFFF3 1
1 0 0 2 2 00000000000000F0 000000000000003C 0000000000000030 1
1 0 0 3 3 00000000000000F0 000000000000000F 00000000000000FF 1
1 0 0 4 4 00000000000000FF 000000000000000F 00000000000000F0 1
1 0 0 5 5 0000000000000003 0000000000000044 0000000000000030 1
1 0 0 6 6 8000000000000000 000000000000003F 0000000000000001 1
1 0 0 7 7 0000000000000001 FFFFFFFFFFFFFFFF 0000000000000001 1
2 0 1 0 8 0000000100000000 0000000000000003 0000000300000000 2
2 0 1 1 9 0000000000010000 0000000000008000 FFFFFFFF80000000 2
2 0 1 0 A FFFFFFFFFFFFFFFF 0000000000000002 FFFFFFFFFFFFFFFE 2
2 0 1 1 B 0000000100000005 0000000000000003 000000000000000F 2
3 0 2 0 0 0000000000000064 0000000000000007 000000000000000E 3
3 0 2 2 1 FFFFFFFFFFFFFFFF 0000000000000010 000000000000000F 4
3 0 2 0 2 0000000000001234 0000000000000000 FFFFFFFFFFFFFFFF 3
4 0 2 1 3 FFFFFFFF00000064 0000000000000005 0000000000000014 3
4 0 2 3 4 0000000080000007 0000000000000010 0000000000000007 4
4 0 2 1 5 00000000F0000000 0000000000000001 FFFFFFFFF0000000 3
4 0 2 3 6 0000000080000009 0000000000000000 FFFFFFFF80000009 4
5 0 2 0 C 0000000000000064 0000000000000007 0000000000000000 0
5 0 1 0 D 0000000000000005 0000000000000006 0000000000000000 0
5 1 0 0 0 0000000000000000 0000000000000000 0000000000000000 0
5 0 0 0 E 0000000000000005 0000000000000006 000000000000000B 1
5 0 2 0 F 0000000000000064 000000000000000A 000000000000000A 3
